/* src/sd_cfg.svh */
`ifndef SD_CFG_SVH
`define SD_CFG_SVH

// ==============================
// Frame geometry
// ==============================

// Whole command or response frame on the CMD line
`define SD_FRAME_BITS 48
// Start bit through argument, the span covered by the CRC
`define SD_BODY_BITS 40
`define SD_CRC_BITS 7

`endif

/* src/sd_frame_pkg.sv */
`include "sd_cfg.svh"

package sd_frame_pkg;

    // ==============================
    // Frame layout on the CMD line
    // ==============================

    // Field order matches the wire, MSB goes out first
    typedef struct packed {
        logic                    start_bit;
        logic                    tx_bit;
        logic [5:0]              index;
        logic [31:0]             arg;
        logic [`SD_CRC_BITS-1:0] crc;
        logic                    end_bit;
    } sd_frame_t;

    // Shifted bit by bit as raw, decoded as fields
    typedef union packed {
        logic [`SD_FRAME_BITS-1:0] raw;
        sd_frame_t                 fields;
    } sd_word_u;

endpackage

/* src/sd_status_pkg.sv */
package sd_status_pkg;

    // ==============================
    // Response check results
    // ==============================

    // One flag per failed check
    typedef struct packed {
        logic crc_err;
        logic tx_err;
        logic end_err;
    } resp_err_t;

endpackage

/* src/resp_if.sv */
interface resp_if import sd_frame_pkg::*; ();

    // High while a frame bit is on bit_data
    logic     bit_valid;
    logic     bit_data;
    // One cycle after the last frame bit
    logic     frame_end;
    // Held from frame_end until the next start bit
    sd_word_u word;

    modport receiver (
        output bit_valid,
        output bit_data,
        output frame_end,
        output word
    );

    // Listens only, no back-pressure
    modport check (
        input bit_valid,
        input bit_data,
        input frame_end,
        input word
    );

endinterface

/* src/crc7.sv */
`include "sd_cfg.svh"

module crc7 (
    input  logic                    clk_int,
    input  logic                    rstSync_,
    input  logic                    clear,
    input  logic                    en,
    input  logic                    din,
    output logic [`SD_CRC_BITS-1:0] crc
);

    logic feedback;

    // Generator x^7 + x^3 + 1
    assign feedback = din ^ crc[`SD_CRC_BITS-1];

    always_ff @(posedge clk_int or negedge rstSync_) begin
        if (!rstSync_) begin
            crc <= '0;
        end else if (clear) begin
            crc <= '0;
        end else if (en) begin
            // Taps at bit 0 and bit 3
            crc <= {crc[5:3], crc[2] ^ feedback, crc[1:0], feedback};
        end
    end

endmodule

/* src/sd_cmd_sender.sv */
`include "sd_cfg.svh"

module sd_cmd_sender import sd_frame_pkg::*; (
    input  logic     clk_int,
    input  logic     rstSync_,
    input  logic     cmd_trigger,
    input  sd_word_u cmd_word,
    input  logic     resp_en,
    input  logic     resp_busy,
    output logic     cmd_out,
    output logic     cmd_oe,
    output logic     cmd_done,
    output logic     cmd_busy,
    output logic     resp_arm
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_BODY = 2'd1;
    localparam logic [1:0] ST_CRC  = 2'd2;
    localparam logic [1:0] ST_END  = 2'd3;

    logic [1:0]              state_q;
    logic [5:0]              cnt_q;
    logic                    resp_en_q;
    logic                    start;
    sd_word_u                shift_q;
    logic [`SD_CRC_BITS-1:0] crc;

    // Busy through the done cycle, then for as long as a response is pending
    assign cmd_oe   = (state_q != ST_IDLE);
    assign cmd_busy = cmd_oe || cmd_done || resp_busy;
    assign start    = cmd_trigger && !cmd_busy;

    // Body from the shift register, then CRC MSB first, then end bit
    always_comb begin
        case (state_q)
            ST_BODY: cmd_out = shift_q.raw[`SD_FRAME_BITS-1];
            ST_CRC:  cmd_out = crc[cnt_q[2:0]];
            default: cmd_out = 1'b1;
        endcase
    end

    // ==============================
    // Command FSM
    // ==============================
    always_ff @(posedge clk_int or negedge rstSync_) begin
        if (!rstSync_) begin
            state_q   <= ST_IDLE;
            cnt_q     <= '0;
            resp_en_q <= 1'b0;
            cmd_done  <= 1'b0;
            resp_arm  <= 1'b0;
        end else begin
            cmd_done <= 1'b0;
            resp_arm <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (start) begin
                        state_q   <= ST_BODY;
                        cnt_q     <= 6'(`SD_BODY_BITS - 1);
                        resp_en_q <= resp_en;
                    end
                end
                ST_BODY: begin
                    if (cnt_q == '0) begin
                        state_q <= ST_CRC;
                        cnt_q   <= 6'(`SD_CRC_BITS - 1);
                    end else begin
                        cnt_q <= cnt_q - 6'd1;
                    end
                end
                ST_CRC: begin
                    if (cnt_q == '0) begin
                        state_q <= ST_END;
                    end else begin
                        cnt_q <= cnt_q - 6'd1;
                    end
                end
                default: begin
                    state_q  <= ST_IDLE;
                    cmd_done <= 1'b1;
                    resp_arm <= resp_en_q;
                end
            endcase
        end
    end

    always_ff @(posedge clk_int) begin
        if (start) begin
            shift_q <= cmd_word;
        end else if (state_q == ST_BODY) begin
            shift_q.raw <= {shift_q.raw[`SD_FRAME_BITS-2:0], 1'b0};
        end
    end

    // CRC covers the body bits only
    crc7 i_crc7 (
        .clk_int  (clk_int),
        .rstSync_ (rstSync_),
        .clear    (start),
        .en       (state_q == ST_BODY),
        .din      (shift_q.raw[`SD_FRAME_BITS-1]),
        .crc      (crc)
    );

endmodule

/* src/sd_resp_receiver.sv */
`include "sd_cfg.svh"

module sd_resp_receiver import sd_frame_pkg::*; (
    input  logic     clk_int,
    input  logic     rstSync_,
    input  logic     resp_arm,
    input  logic     cmd_in,
    output logic     resp_busy,
    resp_if.receiver rx
);

    localparam logic [1:0] RX_IDLE  = 2'd0;
    localparam logic [1:0] RX_TURN  = 2'd1;
    localparam logic [1:0] RX_WAIT  = 2'd2;
    localparam logic [1:0] RX_SHIFT = 2'd3;

    // Cycles where cmd_in is ignored while the line turns around
    localparam int TURN_CYCLES = 2;

    logic       cmd_in_q;
    logic [1:0] state_q;
    logic [5:0] cnt_q;
    sd_word_u   shift_q;

    // Start bit is the first frame bit
    assign rx.bit_valid = ((state_q == RX_WAIT) && !cmd_in_q) || (state_q == RX_SHIFT);
    assign rx.bit_data  = cmd_in_q;
    assign rx.word      = shift_q;

    // ==============================
    // Response FSM
    // ==============================
    always_ff @(posedge clk_int or negedge rstSync_) begin
        if (!rstSync_) begin
            cmd_in_q     <= 1'b1;
            state_q      <= RX_IDLE;
            cnt_q        <= '0;
            resp_busy    <= 1'b0;
            rx.frame_end <= 1'b0;
        end else begin
            cmd_in_q     <= cmd_in;
            rx.frame_end <= 1'b0;
            case (state_q)
                RX_IDLE: begin
                    if (resp_arm) begin
                        state_q   <= RX_TURN;
                        cnt_q     <= 6'(TURN_CYCLES - 1);
                        resp_busy <= 1'b1;
                    end
                end
                RX_TURN: begin
                    if (cnt_q == '0) begin
                        state_q <= RX_WAIT;
                    end else begin
                        cnt_q <= cnt_q - 6'd1;
                    end
                end
                RX_WAIT: begin
                    // Card idles high, first low bit starts the frame
                    if (!cmd_in_q) begin
                        state_q <= RX_SHIFT;
                        cnt_q   <= 6'(`SD_FRAME_BITS - 2);
                    end
                end
                default: begin
                    if (cnt_q == '0) begin
                        state_q      <= RX_IDLE;
                        resp_busy    <= 1'b0;
                        rx.frame_end <= 1'b1;
                    end else begin
                        cnt_q <= cnt_q - 6'd1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_int) begin
        if (rx.bit_valid) begin
            shift_q.raw <= {shift_q.raw[`SD_FRAME_BITS-2:0], cmd_in_q};
        end
    end

endmodule

/* src/sd_resp_checker.sv */
`include "sd_cfg.svh"

module sd_resp_checker import sd_frame_pkg::*; import sd_status_pkg::*; (
    input  logic     clk_int,
    input  logic     rstSync_,
    resp_if.check    rx,
    output logic     resp_done,
    output sd_word_u resp_word,
    output logic     resp_crc_err,
    output logic     resp_frame_err
);

    logic [5:0]              bit_cnt_q;
    logic                    crc_en;
    logic [`SD_CRC_BITS-1:0] crc;
    resp_err_t               err;
    resp_err_t               err_q;

    // Only start bit through argument go into the CRC
    assign crc_en = rx.bit_valid && (bit_cnt_q < 6'(`SD_BODY_BITS));

    crc7 i_crc7 (
        .clk_int  (clk_int),
        .rstSync_ (rstSync_),
        .clear    (rx.frame_end),
        .en       (crc_en),
        .din      (rx.bit_data),
        .crc      (crc)
    );

    // ==============================
    // Frame checks
    // ==============================
    always_comb begin
        err.crc_err = (crc != rx.word.fields.crc);
        // Card to host frames carry a zero transmission bit
        err.tx_err  = rx.word.fields.tx_bit;
        err.end_err = !rx.word.fields.end_bit;
    end

    always_ff @(posedge clk_int or negedge rstSync_) begin
        if (!rstSync_) begin
            bit_cnt_q <= '0;
            resp_done <= 1'b0;
            resp_word <= '0;
            err_q     <= '0;
        end else begin
            resp_done <= rx.frame_end;
            if (rx.frame_end) begin
                bit_cnt_q <= '0;
                resp_word <= rx.word;
                err_q     <= err;
            end else if (rx.bit_valid) begin
                bit_cnt_q <= bit_cnt_q + 6'd1;
            end
        end
    end

    assign resp_crc_err   = err_q.crc_err;
    assign resp_frame_err = err_q.tx_err | err_q.end_err;

endmodule

/* src/sd_cmd_ctrl.sv */
module sd_cmd_ctrl import sd_frame_pkg::*; (
    input  logic     clk_int,
    input  logic     rstSync_,
    // Command request
    input  sd_word_u cmd_word,
    input  logic     resp_en,
    input  logic     cmd_trigger,
    output logic     cmd_busy,
    output logic     cmd_done,
    // CMD line
    output logic     cmd_out,
    output logic     cmd_oe,
    input  logic     cmd_in,
    // Response status
    output logic     resp_done,
    output sd_word_u resp_word,
    output logic     resp_crc_err,
    output logic     resp_frame_err
);

    logic resp_arm;
    logic resp_busy;

    resp_if i_resp_if ();

    // ==============================
    // Stages
    // ==============================
    sd_cmd_sender i_sd_cmd_sender (
        .clk_int     (clk_int),
        .rstSync_    (rstSync_),
        .cmd_trigger (cmd_trigger),
        .cmd_word    (cmd_word),
        .resp_en     (resp_en),
        .resp_busy   (resp_busy),
        .cmd_out     (cmd_out),
        .cmd_oe      (cmd_oe),
        .cmd_done    (cmd_done),
        .cmd_busy    (cmd_busy),
        .resp_arm    (resp_arm)
    );

    sd_resp_receiver i_sd_resp_receiver (
        .clk_int   (clk_int),
        .rstSync_  (rstSync_),
        .resp_arm  (resp_arm),
        .cmd_in    (cmd_in),
        .resp_busy (resp_busy),
        .rx        (i_resp_if.receiver)
    );

    sd_resp_checker i_sd_resp_checker (
        .clk_int        (clk_int),
        .rstSync_       (rstSync_),
        .rx             (i_resp_if.check),
        .resp_done      (resp_done),
        .resp_word      (resp_word),
        .resp_crc_err   (resp_crc_err),
        .resp_frame_err (resp_frame_err)
    );

endmodule

/* tests/sd_cmd_monitor.sv */
`include "sd_cfg.svh"

module sd_cmd_monitor import sd_frame_pkg::*; import sd_status_pkg::*; (
    input  logic                      clk_int,
    input  logic                      rstSync_,
    input  logic                      cmd_out,
    input  logic                      cmd_oe,
    input  logic                      cmd_done,
    input  logic                      cmd_busy,
    input  logic                      resp_done,
    input  sd_word_u                  resp_word,
    input  logic                      resp_crc_err,
    input  logic                      resp_frame_err,
    // Expectations of the running test
    input  logic                      test_active,
    input  logic                      test_end,
    input  int                        test_id,
    input  logic [`SD_FRAME_BITS-1:0] exp_cmd,
    input  logic                      exp_resp_en,
    input  logic [`SD_FRAME_BITS-1:0] exp_resp,
    input  resp_err_t                 exp_err,
    output int                        pass_cnt,
    output int                        fail_cnt
);

    logic [`SD_FRAME_BITS-1:0] cmd_cap;
    logic                      oe_prev;
    logic                      done_prev;
    logic                      exp_frame_err;
    int                        oe_cycles;
    int                        oe_rises;
    int                        done_cnt;
    int                        resp_cnt;
    int                        errs;

    assign exp_frame_err = exp_err.tx_err | exp_err.end_err;

    task clear_test();
        cmd_cap   = '0;
        oe_prev   = 1'b0;
        done_prev = 1'b0;
        oe_cycles = 0;
        oe_rises  = 0;
        done_cnt  = 0;
        resp_cnt  = 0;
        errs      = 0;
    endtask

    // ==============================
    // Per cycle checks
    // ==============================
    task sample_cycle();
        if (cmd_oe) begin
            cmd_cap = {cmd_cap[`SD_FRAME_BITS-2:0], cmd_out};
            oe_cycles++;
            if (!oe_prev) oe_rises++;
        end
        if (cmd_done) begin
            done_cnt++;
            if (cmd_oe || !oe_prev) begin
                $display("Test %0d: cmd_done did not come right after cmd_oe fell", test_id);
                errs++;
            end
        end
        // Busy drops at once unless a response is pending
        if (done_prev && !cmd_done && (cmd_busy !== exp_resp_en)) begin
            $display("[FAIL] test %0d cmd_busy: expected %h, actual %h",
                     test_id, exp_resp_en, cmd_busy);
            errs++;
        end
        if (resp_done) begin
            resp_cnt++;
            if (resp_word.raw !== exp_resp) begin
                $display("[FAIL] test %0d resp_word: expected %h, actual %h",
                         test_id, exp_resp, resp_word.raw);
                errs++;
            end
            if (resp_crc_err !== exp_err.crc_err) begin
                $display("[FAIL] test %0d resp_crc_err: expected %h, actual %h",
                         test_id, exp_err.crc_err, resp_crc_err);
                errs++;
            end
            if (resp_frame_err !== exp_frame_err) begin
                $display("[FAIL] test %0d resp_frame_err: expected %h, actual %h",
                         test_id, exp_frame_err, resp_frame_err);
                errs++;
            end
        end
        oe_prev   = cmd_oe;
        done_prev = cmd_done;
    endtask

    task finish_test();
        if (oe_cycles != `SD_FRAME_BITS) begin
            $display("[FAIL] test %0d cmd_oe cycles: expected %h, actual %h",
                     test_id, `SD_FRAME_BITS, oe_cycles);
            errs++;
        end
        if (oe_rises != 1) begin
            $display("Test %0d: cmd_oe rose %0d times instead of once", test_id, oe_rises);
            errs++;
        end
        if (cmd_cap !== exp_cmd) begin
            $display("[FAIL] test %0d cmd_out frame: expected %h, actual %h",
                     test_id, exp_cmd, cmd_cap);
            errs++;
        end
        if (done_cnt != 1) begin
            $display("Test %0d: expected one cmd_done pulse but saw %0d", test_id, done_cnt);
            errs++;
        end
        if (resp_cnt != (exp_resp_en ? 1 : 0)) begin
            $display("Test %0d: saw %0d resp_done pulses with resp_en %0d",
                     test_id, resp_cnt, exp_resp_en);
            errs++;
        end
        if (errs == 0) begin
            pass_cnt++;
            $display("Test %0d passed", test_id);
        end else begin
            fail_cnt++;
            $display("Test %0d failed with %0d errors", test_id, errs);
        end
        clear_test();
    endtask

    always @(posedge clk_int or negedge rstSync_) begin
        if (!rstSync_) begin
            pass_cnt = 0;
            fail_cnt = 0;
            clear_test();
        end else if (test_end) begin
            finish_test();
        end else if (test_active) begin
            sample_cycle();
        end
    end

endmodule

/* tests/sd_cmd_ctrl_tb.sv */
`include "sd_cfg.svh"

module sd_cmd_ctrl_tb import sd_frame_pkg::*; import sd_status_pkg::*; ();

    localparam int NUM_TESTS = 7;
    localparam int MAX_DELAY = 12;
    localparam int TIMEOUT_CYCLES =
        NUM_TESTS * (`SD_FRAME_BITS + MAX_DELAY + `SD_FRAME_BITS + 20);

    localparam logic [1:0] CORRUPT_NONE = 2'd0;
    localparam logic [1:0] CORRUPT_CRC  = 2'd1;
    localparam logic [1:0] CORRUPT_TX   = 2'd2;
    localparam logic [1:0] CORRUPT_END  = 2'd3;

    typedef struct packed {
        logic [5:0] cmd_index;
        logic       resp_en;
        logic [7:0] delay;
        logic [5:0] resp_index;
        logic [1:0] corrupt;
        logic       retrig;
        resp_err_t  exp_err;
    } test_entry_t;

    test_entry_t tests [NUM_TESTS];
    int          n_entries;
    integer      seed;
    int          cycle_cnt;

    logic      clk_int;
    logic      rstSync_;
    sd_word_u  cmd_word;
    logic      resp_en;
    logic      cmd_trigger;
    logic      cmd_busy;
    logic      cmd_done;
    logic      cmd_out;
    logic      cmd_oe;
    logic      cmd_in;
    logic      resp_done;
    sd_word_u  resp_word;
    logic      resp_crc_err;
    logic      resp_frame_err;

    logic                      test_active;
    logic                      test_end;
    int                        test_id;
    logic [`SD_FRAME_BITS-1:0] exp_cmd;
    logic [`SD_FRAME_BITS-1:0] exp_resp;
    logic                      exp_resp_en;
    resp_err_t                 exp_err;
    int                        pass_cnt;
    int                        fail_cnt;

    sd_cmd_ctrl i_sd_cmd_ctrl (
        .clk_int        (clk_int),
        .rstSync_       (rstSync_),
        .cmd_word       (cmd_word),
        .resp_en        (resp_en),
        .cmd_trigger    (cmd_trigger),
        .cmd_busy       (cmd_busy),
        .cmd_done       (cmd_done),
        .cmd_out        (cmd_out),
        .cmd_oe         (cmd_oe),
        .cmd_in         (cmd_in),
        .resp_done      (resp_done),
        .resp_word      (resp_word),
        .resp_crc_err   (resp_crc_err),
        .resp_frame_err (resp_frame_err)
    );

    sd_cmd_monitor i_sd_cmd_monitor (
        .clk_int        (clk_int),
        .rstSync_       (rstSync_),
        .cmd_out        (cmd_out),
        .cmd_oe         (cmd_oe),
        .cmd_done       (cmd_done),
        .cmd_busy       (cmd_busy),
        .resp_done      (resp_done),
        .resp_word      (resp_word),
        .resp_crc_err   (resp_crc_err),
        .resp_frame_err (resp_frame_err),
        .test_active    (test_active),
        .test_end       (test_end),
        .test_id        (test_id),
        .exp_cmd        (exp_cmd),
        .exp_resp_en    (exp_resp_en),
        .exp_resp       (exp_resp),
        .exp_err        (exp_err),
        .pass_cnt       (pass_cnt),
        .fail_cnt       (fail_cnt)
    );

    initial begin
        clk_int = 1'b0;
        forever #5 clk_int = ~clk_int;
    end

    // Remainder of the body divided by x^7 + x^3 + 1 from a zero start
    function automatic logic [6:0] calc_crc7(input logic [`SD_BODY_BITS-1:0] body);
        logic [6:0] rem;
        logic       top;
        rem = '0;
        for (int i = `SD_BODY_BITS - 1; i >= 0; i--) begin
            top = body[i] ^ rem[6];
            rem = {rem[5:0], 1'b0};
            if (top) rem = rem ^ 7'h09;
        end
        return rem;
    endfunction

    task add_entry(input logic [5:0] cmd_index, input logic en, input logic [7:0] delay,
                   input logic [5:0] resp_index, input logic [1:0] corrupt,
                   input logic retrig, input resp_err_t err);
        tests[n_entries].cmd_index  = cmd_index;
        tests[n_entries].resp_en    = en;
        tests[n_entries].delay      = delay;
        tests[n_entries].resp_index = resp_index;
        tests[n_entries].corrupt    = corrupt;
        tests[n_entries].retrig     = retrig;
        tests[n_entries].exp_err    = err;
        n_entries++;
    endtask

    // Card model drives the frame MSB first and idles high
    task automatic send_card_frame(input logic [`SD_FRAME_BITS-1:0] frame, input int gap);
        repeat (gap) begin
            @(posedge clk_int);
            #1;
        end
        for (int i = `SD_FRAME_BITS - 1; i >= 0; i--) begin
            cmd_in = frame[i];
            @(posedge clk_int);
            #1;
        end
        cmd_in = 1'b1;
    endtask

    // ==============================
    // One table entry
    // ==============================
    task automatic run_entry(input int idx);
        test_entry_t                t;
        logic [31:0]                cmd_arg;
        logic [31:0]                resp_arg;
        logic [7:0]                 junk;
        logic [`SD_BODY_BITS-1:0]   resp_body;
        logic [`SD_FRAME_BITS-1:0]  resp_frame;
        int                         oe_cycle;
        t         = tests[idx];
        cmd_arg   = $random(seed);
        resp_arg  = $random(seed);
        junk      = 8'($random(seed));
        resp_body = {1'b0, 1'b0, t.resp_index, resp_arg};
        resp_frame = {resp_body, calc_crc7(resp_body), 1'b1};
        case (t.corrupt)
            CORRUPT_CRC: resp_frame[1] = ~resp_frame[1];
            CORRUPT_TX:  resp_frame[`SD_FRAME_BITS-2] = 1'b1;
            CORRUPT_END: resp_frame[0] = 1'b0;
            default:     ;
        endcase
        while (cmd_busy) begin
            @(posedge clk_int);
            #1;
        end
        // DUT overwrites the junk low byte with CRC and end bit
        cmd_word.raw = {1'b0, 1'b1, t.cmd_index, cmd_arg, junk};
        exp_cmd      = {cmd_word.raw[`SD_FRAME_BITS-1:8],
                        calc_crc7(cmd_word.raw[`SD_FRAME_BITS-1:8]), 1'b1};
        exp_resp     = resp_frame;
        exp_resp_en  = t.resp_en;
        exp_err      = t.exp_err;
        test_id      = idx;
        resp_en      = t.resp_en;
        cmd_trigger  = 1'b1;
        test_active  = 1'b1;
        @(posedge clk_int);
        #1;
        cmd_trigger = 1'b0;
        oe_cycle    = 0;
        while (!cmd_done) begin
            cmd_trigger = t.retrig && (oe_cycle == 20);
            @(posedge clk_int);
            #1;
            oe_cycle++;
        end
        // Busy is still high in the cmd_done cycle
        cmd_trigger = t.retrig;
        @(posedge clk_int);
        #1;
        cmd_trigger = 1'b0;
        send_card_frame(resp_frame, t.delay - 1);
        if (t.resp_en) begin
            while (!resp_done) begin
                @(posedge clk_int);
                #1;
            end
        end else begin
            repeat (4) begin
                @(posedge clk_int);
                #1;
            end
        end
        @(posedge clk_int);
        #1;
        test_active = 1'b0;
        test_end    = 1'b1;
        @(posedge clk_int);
        #1;
        test_end = 1'b0;
    endtask

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk_int);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles, the DUT stopped making progress", cycle_cnt);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        seed         = 32'h461e_ca1b;
        rstSync_     = 1'b0;
        cmd_word     = '0;
        resp_en      = 1'b0;
        cmd_trigger  = 1'b0;
        cmd_in       = 1'b1;
        test_active  = 1'b0;
        test_end     = 1'b0;
        test_id      = 0;
        exp_cmd      = '0;
        exp_resp     = '0;
        exp_resp_en  = 1'b0;
        exp_err      = '0;
        n_entries    = 0;
        // Card answers although no response is expected
        add_entry(6'd0,  1'b0, 8'd4,  6'd0,  CORRUPT_NONE, 1'b0, 3'b000);
        add_entry(6'd8,  1'b1, 8'd3,  6'd8,  CORRUPT_NONE, 1'b0, 3'b000);
        add_entry(6'd17, 1'b1, 8'd9,  6'd17, CORRUPT_CRC,  1'b0, 3'b100);
        // Card CRC is computed before the tx bit flips
        add_entry(6'd55, 1'b1, 8'd5,  6'd55, CORRUPT_TX,   1'b0, 3'b110);
        add_entry(6'd41, 1'b1, 8'd12, 6'd41, CORRUPT_END,  1'b0, 3'b001);
        add_entry(6'd2,  1'b1, 8'd6,  6'd2,  CORRUPT_NONE, 1'b1, 3'b000);
        add_entry(6'd7,  1'b0, 8'd3,  6'd7,  CORRUPT_NONE, 1'b1, 3'b000);
        repeat (16) @(posedge clk_int);
        #1;
        rstSync_ = 1'b1;
        @(posedge clk_int);
        #1;
        for (int i = 0; i < NUM_TESTS; i++) begin
            run_entry(i);
        end
        $display("Tests run %0d, passed %0d, failed %0d", NUM_TESTS, pass_cnt, fail_cnt);
        if ((fail_cnt == 0) && (pass_cnt == NUM_TESTS)) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* sd_cmd_ctrl.f */
+incdir+src
src/sd_frame_pkg.sv
src/sd_status_pkg.sv
src/resp_if.sv
src/crc7.sv
src/sd_cmd_sender.sv
src/sd_resp_receiver.sv
src/sd_resp_checker.sv
src/sd_cmd_ctrl.sv
tests/sd_cmd_monitor.sv
tests/sd_cmd_ctrl_tb.sv
